/* mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Data cache geometry
`define DC_LINES        64
`define DC_LINE_BITS    128
`define DC_INDEX_BITS   6
`define DC_TAG_BITS     22

// I/O address map
`define IO_SEL_BIT      30     // Address bit that picks the I/O block
`define IO_REG_BITS     4

// PWM channel counters
`define PWM_BITS        16

`endif

/* mem_pkg.sv */
`default_nettype none

`include "mem_params.svh"

package mem_pkg;

    // funct3 width codes, stores reuse B/H/W
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_BU = 3'b100,
        LS_HU = 3'b101
    } ls_op_e;

    typedef struct packed {
        logic        read;
        logic        write;
        ls_op_e      op;
        logic [31:0] addr;      // Also carries the ALU result
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic        reg_write;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        load;
    } wb_t;

    // One line transfer to or from main memory
    typedef struct packed {
        logic                      req;
        logic                      we;
        logic [31:0]               addr;   // Line aligned
        logic [`DC_LINE_BITS-1:0]  line;
    } line_xfer_t;

    typedef struct packed {
        logic [`DC_TAG_BITS-1:0]   tag;
        logic [`DC_INDEX_BITS-1:0] index;
        logic [1:0]                word;
        logic [1:0]                byte_off;
    } cache_addr_t;

    typedef struct packed {
        logic [31-`IO_REG_BITS-2:0] region;
        logic [`IO_REG_BITS-1:0]    reg_num;
        logic [1:0]                 byte_off;  // Word registers only
    } io_addr_t;

    // Same address word, seen by the cache or by the I/O block
    typedef union packed {
        cache_addr_t cache;
        io_addr_t    io;
    } mem_addr_u;

endpackage

`default_nettype wire

/* dcache.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_params.svh"

module dcache (
    input  wire logic                     clk_i,
    input  wire logic                     rst_i,
    input  wire logic                     en_i,
    input  wire mem_pkg::mem_req_t        req_i,
    output      logic                     hit_o,
    output      logic                     busy_o,
    output      logic [31:0]              rdata_o,
    output      mem_pkg::line_xfer_t      mem_o,
    input  wire logic                     mem_avail_i,
    input  wire logic                     mem_ready_i,
    input  wire logic [`DC_LINE_BITS-1:0] mem_rline_i
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WB,       // Victim line going out
        S_REFILL,   // Waiting for the new line
        S_FILL      // Writing it into the arrays
    } state_e;

    logic [`DC_LINE_BITS-1:0] data_q [`DC_LINES];
    logic [`DC_TAG_BITS-1:0]  tag_q  [`DC_LINES];
    logic [`DC_LINES-1:0]     valid_q;
    logic [`DC_LINES-1:0]     dirty_q;

    state_e                    state_q;
    logic                      req_q;
    logic [`DC_LINE_BITS-1:0]  fill_q;

    mem_addr_u                 a;
    logic [`DC_INDEX_BITS-1:0] idx;
    logic                      access;
    logic                      store_hit;
    logic [`DC_LINE_BITS-1:0]  cur_line;
    logic [`DC_LINE_BITS-1:0]  st_line;
    logic [31:0]               st_word;
    logic [3:0]                be;
    logic [31:0]               rword;
    logic [7:0]                rbyte;
    logic [15:0]               rhalf;

    assign a   = req_i.addr;
    assign idx = a.cache.index;

    assign access    = en_i & (req_i.read | req_i.write);
    assign hit_o     = access & valid_q[idx] & (tag_q[idx] == a.cache.tag);
    assign busy_o    = (state_q != S_IDLE) | (access & ~hit_o);
    assign store_hit = (state_q == S_IDLE) & hit_o & req_i.write;
    assign cur_line  = data_q[idx];

    // Load alignment and extension
    assign rword = cur_line[{a.cache.word, 5'd0} +: 32];
    assign rbyte = rword[{a.cache.byte_off, 3'd0} +: 8];
    assign rhalf = rword[{a.cache.byte_off[1], 4'd0} +: 16];

    always_comb begin
        case (req_i.op)
            LS_B:    rdata_o = {{24{rbyte[7]}}, rbyte};
            LS_BU:   rdata_o = {24'd0, rbyte};
            LS_H:    rdata_o = {{16{rhalf[15]}}, rhalf};
            LS_HU:   rdata_o = {16'd0, rhalf};
            default: rdata_o = rword;
        endcase
    end

    // Store lanes, data replicated across the word
    always_comb begin
        case (req_i.op)
            LS_B: begin
                be      = 4'b0001 << a.cache.byte_off;
                st_word = {4{req_i.wdata[7:0]}};
            end
            LS_H: begin
                be      = a.cache.byte_off[1] ? 4'b1100 : 4'b0011;
                st_word = {2{req_i.wdata[15:0]}};
            end
            default: begin
                be      = 4'b1111;
                st_word = req_i.wdata;
            end
        endcase
    end

    always_comb begin
        st_line = cur_line;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                st_line[{a.cache.word, 2'(b), 3'd0} +: 8] = st_word[8*b +: 8];
            end
        end
    end

    // Miss FSM
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= S_IDLE;
            req_q   <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (access && !hit_o) begin
                        state_q <= (valid_q[idx] && dirty_q[idx]) ? S_WB : S_REFILL;
                        req_q   <= 1'b1;
                    end
                end
                S_WB: begin
                    if (req_q && mem_avail_i) begin
                        req_q <= 1'b0;        // Accepted, now wait for completion
                    end else if (!req_q && mem_ready_i) begin
                        state_q <= S_REFILL;
                        req_q   <= 1'b1;
                    end
                end
                S_REFILL: begin
                    if (req_q && mem_avail_i) begin
                        req_q <= 1'b0;
                    end else if (!req_q && mem_ready_i) begin
                        state_q <= S_FILL;
                    end
                end
                S_FILL:  state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == S_REFILL && !req_q && mem_ready_i) begin
            fill_q <= mem_rline_i;
        end
    end

    // Line and tag arrays
    always_ff @(posedge clk_i) begin
        if (state_q == S_FILL) begin
            data_q[idx] <= fill_q;
            tag_q[idx]  <= a.cache.tag;
        end else if (store_hit) begin
            data_q[idx] <= st_line;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (state_q == S_FILL) begin
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= 1'b0;      // Fresh copy from memory
        end else if (store_hit) begin
            dirty_q[idx] <= 1'b1;
        end
    end

    // Main memory side
    always_comb begin
        mem_o.req  = req_q;
        mem_o.we   = (state_q == S_WB);
        mem_o.line = cur_line;
        if (state_q == S_WB) begin
            mem_o.addr = {tag_q[idx], idx, 4'd0};      // Victim address
        end else begin
            mem_o.addr = {a.cache.tag, idx, 4'd0};
        end
    end

endmodule

`default_nettype wire

/* pwm_io.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_params.svh"

module pwm_io (
    input  wire logic              clk_i,
    input  wire logic              rst_i,
    input  wire logic              en_i,
    input  wire mem_pkg::mem_req_t req_i,
    output      logic [31:0]       rdata_o,
    output      logic              pwm0_o,
    output      logic              pwm1_o
);
    import mem_pkg::*;

    localparam int NCH = 2;

    logic [`PWM_BITS-1:0] period_q [NCH];
    logic [`PWM_BITS-1:0] duty_q   [NCH];
    logic [`PWM_BITS-1:0] cnt_q    [NCH];
    logic [NCH-1:0]       pwm_q;

    mem_addr_u              a;
    logic [`IO_REG_BITS-1:0] rnum;
    logic                   wr;

    assign a    = req_i.addr;
    assign rnum = a.io.reg_num;
    assign wr   = en_i & req_i.write;

    // Map: 0/1 period and duty of ch0, 2/3 of ch1, 4/5 counters
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int c = 0; c < NCH; c++) begin
                period_q[c] <= '0;
                duty_q[c]   <= '0;
            end
        end else if (wr) begin
            case (rnum)
                4'd0: period_q[0] <= req_i.wdata[`PWM_BITS-1:0];
                4'd1: duty_q[0]   <= req_i.wdata[`PWM_BITS-1:0];
                4'd2: period_q[1] <= req_i.wdata[`PWM_BITS-1:0];
                4'd3: duty_q[1]   <= req_i.wdata[`PWM_BITS-1:0];
                default: ;                 // Counters are read only
            endcase
        end
    end

    // Free running counters, wrap at period-1
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int c = 0; c < NCH; c++) begin
                cnt_q[c] <= '0;
            end
            pwm_q <= '0;
        end else begin
            for (int c = 0; c < NCH; c++) begin
                if (period_q[c] == '0 || cnt_q[c] >= period_q[c] - 1'b1) begin
                    cnt_q[c] <= '0;
                end else begin
                    cnt_q[c] <= cnt_q[c] + 1'b1;
                end
                pwm_q[c] <= (cnt_q[c] < duty_q[c]);
            end
        end
    end

    assign pwm0_o = pwm_q[0];
    assign pwm1_o = pwm_q[1];

    always_comb begin
        rdata_o = 32'd0;
        case (rnum)
            4'd0: rdata_o[`PWM_BITS-1:0] = period_q[0];
            4'd1: rdata_o[`PWM_BITS-1:0] = duty_q[0];
            4'd2: rdata_o[`PWM_BITS-1:0] = period_q[1];
            4'd3: rdata_o[`PWM_BITS-1:0] = duty_q[1];
            4'd4: rdata_o[`PWM_BITS-1:0] = cnt_q[0];    // Live count
            4'd5: rdata_o[`PWM_BITS-1:0] = cnt_q[1];
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* mem_stage_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_params.svh"

module mem_stage_ctrl (
    input  wire logic              clk_i,
    input  wire logic              rst_i,
    input  wire mem_pkg::mem_req_t req_i,
    input  wire logic              reg_write_i,
    input  wire logic [4:0]        rd_i,
    output      logic              cache_en_o,
    output      logic              io_en_o,
    input  wire logic              cache_hit_i,
    input  wire logic              cache_busy_i,
    input  wire logic [31:0]       cache_rdata_i,
    input  wire logic [31:0]       io_rdata_i,
    output      logic              stall_o,
    output      mem_pkg::wb_t      wb_o
);
    import mem_pkg::*;

    logic        is_io;
    logic        mem_access;
    logic [31:0] data_sel;

    logic        reg_write_q;
    logic [4:0]  rd_q;
    logic [31:0] data_q;
    logic        load_q;

    // Address steering
    assign is_io      = req_i.addr[`IO_SEL_BIT];
    assign mem_access = req_i.read | req_i.write;
    assign cache_en_o = mem_access & ~is_io;
    assign io_en_o    = mem_access & is_io;

    // Only the cache can hold the pipe
    assign stall_o = cache_en_o & cache_busy_i;

    always_comb begin
        if (req_i.read && io_en_o) begin
            data_sel = io_rdata_i;
        end else if (req_i.read && cache_en_o && cache_hit_i) begin
            data_sel = cache_rdata_i;
        end else if (req_i.write) begin
            data_sel = req_i.wdata;         // Store data rides along
        end else begin
            data_sel = req_i.addr;          // ALU result
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            reg_write_q <= 1'b0;
        end else if (stall_o) begin
            reg_write_q <= 1'b0;            // Bubble into write-back
        end else begin
            reg_write_q <= reg_write_i;
        end
    end

    // Payload holds through a stall
    always_ff @(posedge clk_i) begin
        if (!stall_o) begin
            rd_q   <= rd_i;
            data_q <= data_sel;
            load_q <= req_i.read;
        end
    end

    always_comb begin
        wb_o.reg_write = reg_write_q;
        wb_o.rd        = rd_q;
        wb_o.data      = data_q;
        wb_o.load      = load_q;
    end

endmodule

`default_nettype wire

/* mem_stage_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_params.svh"

module mem_stage_top (
    input  wire logic                     clk_i,
    input  wire logic                     rst_i,
    input  wire mem_pkg::mem_req_t        req_i,
    input  wire logic                     reg_write_i,
    input  wire logic [4:0]               rd_i,
    output      logic                     stall_o,
    output      mem_pkg::wb_t             wb_o,
    output      mem_pkg::line_xfer_t      mem_o,
    input  wire logic                     mem_avail_i,
    input  wire logic                     mem_ready_i,
    input  wire logic [`DC_LINE_BITS-1:0] mem_rline_i,
    output      logic                     pwm0_o,
    output      logic                     pwm1_o
);
    logic        cache_en;
    logic        io_en;
    logic        cache_hit;
    logic        cache_busy;
    logic [31:0] cache_rdata;
    logic [31:0] io_rdata;

    dcache u_dcache (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .en_i        (cache_en),
        .req_i       (req_i),
        .hit_o       (cache_hit),
        .busy_o      (cache_busy),
        .rdata_o     (cache_rdata),
        .mem_o       (mem_o),
        .mem_avail_i (mem_avail_i),
        .mem_ready_i (mem_ready_i),
        .mem_rline_i (mem_rline_i)
    );

    pwm_io u_pwm_io (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .en_i    (io_en),
        .req_i   (req_i),
        .rdata_o (io_rdata),
        .pwm0_o  (pwm0_o),
        .pwm1_o  (pwm1_o)
    );

    mem_stage_ctrl u_ctrl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .req_i         (req_i),
        .reg_write_i   (reg_write_i),
        .rd_i          (rd_i),
        .cache_en_o    (cache_en),
        .io_en_o       (io_en),
        .cache_hit_i   (cache_hit),
        .cache_busy_i  (cache_busy),
        .cache_rdata_i (cache_rdata),
        .io_rdata_i    (io_rdata),
        .stall_o       (stall_o),
        .wb_o          (wb_o)
    );

endmodule

`default_nettype wire

/* tb_mem_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_params.svh"

module tb_mem_stage;
    import mem_pkg::*;

    localparam int          TIMEOUT    = 200;      // Cycles allowed per wait
    localparam int          MEM_WORDS  = 4096;     // 16 KB of main memory
    localparam logic [31:0] IO_BASE    = 32'h4000_0000;
    localparam int          PWM_PERIOD = 10;
    localparam int          PWM_DUTY   = 3;

    logic                     clk_i;
    logic                     rst_i;
    mem_req_t                 req_i;
    logic                     reg_write_i;
    logic [4:0]               rd_i;
    logic                     stall_o;
    wb_t                      wb_o;
    line_xfer_t               mem_o;
    logic                     mem_avail_i;
    logic                     mem_ready_i;
    logic [`DC_LINE_BITS-1:0] mem_rline_i;
    logic                     pwm0_o;
    logic                     pwm1_o;

    logic [31:0]  mem_words [MEM_WORDS];
    logic [7:0]   shadow    [4*MEM_WORDS];    // What the program expects to see

    line_xfer_t   xfer;
    int           delay;
    int           rd_count;
    int           wr_count;
    logic [31:0]  last_rd_addr;
    logic [31:0]  last_wb_addr;
    logic [127:0] last_wb_line;

    wb_t          wb_seen;
    int           stall_cycles;
    int           early_writes;
    int           checks;
    int           errors;

    mem_stage_top UUT (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (req_i),
        .reg_write_i (reg_write_i),
        .rd_i        (rd_i),
        .stall_o     (stall_o),
        .wb_o        (wb_o),
        .mem_o       (mem_o),
        .mem_avail_i (mem_avail_i),
        .mem_ready_i (mem_ready_i),
        .mem_rline_i (mem_rline_i),
        .pwm0_o      (pwm0_o),
        .pwm1_o      (pwm1_o)
    );

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] fill_word(input logic [11:0] w);
        return (32'(w) * 32'h9e37_79b1) ^ {20'h5a3c1, w};
    endfunction

    function automatic logic [127:0] read_line(input logic [31:0] addr);
        logic [127:0] line;
        for (int k = 0; k < 4; k++) begin
            line[32*k +: 32] = mem_words[{addr[13:4], 2'(k)}];
        end
        return line;
    endfunction

    function automatic logic [127:0] shadow_line(input logic [31:0] addr);
        logic [127:0] line;
        for (int i = 0; i < 16; i++) begin
            line[8*i +: 8] = shadow[{addr[13:4], 4'(i)}];
        end
        return line;
    endfunction

    // Little endian, halfwords and words aligned
    function automatic void shadow_store(input ls_op_e op, input logic [31:0] addr,
                                         input logic [31:0] data);
        case (op)
            LS_B: shadow[addr[13:0]] = data[7:0];
            LS_H: begin
                shadow[{addr[13:1], 1'b0}] = data[7:0];
                shadow[{addr[13:1], 1'b1}] = data[15:8];
            end
            default: begin
                for (int b = 0; b < 4; b++) begin
                    shadow[{addr[13:2], 2'(b)}] = data[8*b +: 8];
                end
            end
        endcase
    endfunction

    function automatic logic [31:0] load_expect(input ls_op_e op, input logic [31:0] addr);
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] w;
        b = shadow[addr[13:0]];
        h = {shadow[{addr[13:1], 1'b1}], shadow[{addr[13:1], 1'b0}]};
        w = {shadow[{addr[13:2], 2'd3}], shadow[{addr[13:2], 2'd2}],
             shadow[{addr[13:2], 2'd1}], shadow[{addr[13:2], 2'd0}]};
        case (op)
            LS_B:    return {{24{b[7]}}, b};
            LS_BU:   return {24'd0, b};
            LS_H:    return {{16{h[15]}}, h};
            LS_HU:   return {16'd0, h};
            default: return w;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("Test %-12s done, %0d errors", name, errors - errs_before);
    endtask

    // One request, held until stall_o falls, result taken from wb_o
    task automatic do_access(input string name, input logic rd_en, input logic wr_en,
                             input ls_op_e op, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [4:0] rd_num);
        int waited;
        waited       = 0;
        stall_cycles = 0;
        early_writes = 0;
        @(posedge clk_i);
        #2;
        req_i.read  = rd_en;
        req_i.write = wr_en;
        req_i.op    = op;
        req_i.addr  = addr;
        req_i.wdata = wdata;
        reg_write_i = rd_en;                 // Loads write a register
        rd_i        = rd_num;
        #1;
        while (stall_o && waited < TIMEOUT) begin
            @(posedge clk_i);
            #3;
            waited++;
            stall_cycles++;
            if (wb_o.reg_write) begin
                early_writes++;
            end
        end
        if (stall_o) begin
            errors++;
            $display("Timeout in %s: stall_o stayed high for %0d cycles", name, TIMEOUT);
        end
        @(posedge clk_i);
        #2;
        req_i       = '0;
        reg_write_i = 1'b0;
        #1;
        wb_seen = wb_o;
    endtask

    task automatic store(input string name, input ls_op_e op, input logic [31:0] addr,
                         input logic [31:0] data);
        shadow_store(op, addr, data);
        do_access(name, 1'b0, 1'b1, op, addr, data, 5'd0);
        check_value({name, " reg_write"}, 0, wb_seen.reg_write);
        check_value({name, " data"}, data, wb_seen.data);
        check_value({name, " load flag"}, 0, wb_seen.load);
    endtask

    task automatic load_check(input string name, input ls_op_e op, input logic [31:0] addr,
                              input logic [4:0] rd_num);
        logic [31:0] expected;
        expected = load_expect(op, addr);
        do_access(name, 1'b1, 1'b0, op, addr, 32'd0, rd_num);
        check_value({name, " data"}, expected, wb_seen.data);
        check_value({name, " reg_write"}, 1, wb_seen.reg_write);
        check_value({name, " rd"}, rd_num, wb_seen.rd);
        check_value({name, " load flag"}, 1, wb_seen.load);
    endtask

    task automatic reset_state();
        int errs;
        errs = errors;
        #1;
        check_value("reset stall_o", 0, stall_o);
        check_value("reset mem req", 0, mem_o.req);
        check_value("reset reg_write", 0, wb_o.reg_write);
        check_value("reset pwm0_o", 0, pwm0_o);
        check_value("reset pwm1_o", 0, pwm1_o);
        report_test("reset", errs);
    endtask

    task automatic miss_refill();
        int errs;
        int reads_before;
        errs         = errors;
        reads_before = rd_count;
        load_check("refill LW", LS_W, 32'h0000_0104, 5'd1);
        check_value("refill read count", reads_before + 1, rd_count);
        check_value("refill line address", 32'h0000_0104 & ~32'hf, last_rd_addr);
        report_test("miss refill", errs);
    endtask

    task automatic subword_access();
        int errs;
        errs = errors;
        store("sub SW", LS_W, 32'h0000_0240, 32'h8a5b_c3f1);
        store("sub SB", LS_B, 32'h0000_0241, 32'h0000_009c);
        store("sub SH", LS_H, 32'h0000_0246, 32'h0000_81f2);
        store("sub SB hi", LS_B, 32'h0000_024b, 32'h0000_007e);
        load_check("sub LB", LS_B, 32'h0000_0241, 5'd2);
        load_check("sub LBU", LS_BU, 32'h0000_0241, 5'd3);
        load_check("sub LH", LS_H, 32'h0000_0246, 5'd4);
        load_check("sub LHU", LS_HU, 32'h0000_0246, 5'd5);
        load_check("sub LH lo", LS_H, 32'h0000_0240, 5'd6);
        load_check("sub LHU hi", LS_HU, 32'h0000_0242, 5'd7);
        load_check("sub LB pos", LS_B, 32'h0000_024b, 5'd8);
        load_check("sub LW", LS_W, 32'h0000_0240, 5'd9);
        load_check("sub LW next", LS_W, 32'h0000_0244, 5'd10);
        report_test("sub-word", errs);
    endtask

    // 0x580 and 0x980 share index 24
    task automatic dirty_eviction();
        int           errs;
        int           writes_before;
        logic [127:0] victim;
        errs          = errors;
        writes_before = wr_count;
        store("evict SW", LS_W, 32'h0000_0588, 32'h1357_9bdf);
        store("evict SB", LS_B, 32'h0000_058d, 32'h0000_00e4);
        victim = shadow_line(32'h0000_0580);
        load_check("evict LW other tag", LS_W, 32'h0000_0984, 5'd11);
        check_value("evict write-back count", writes_before + 1, wr_count);
        check_value("evict victim address", 32'h0000_0580, last_wb_addr);
        check_value("evict victim line", victim, last_wb_line);
        load_check("evict reload LW", LS_W, 32'h0000_0588, 5'd12);
        load_check("evict reload LBU", LS_BU, 32'h0000_058d, 5'd13);
        report_test("dirty evict", errs);
    endtask

    task automatic pwm_channel();
        int errs;
        int high0;
        int high1;
        errs  = errors;
        high0 = 0;
        high1 = 0;
        do_access("pwm period", 1'b0, 1'b1, LS_W, IO_BASE, PWM_PERIOD, 5'd0);
        do_access("pwm duty", 1'b0, 1'b1, LS_W, IO_BASE | 32'h4, PWM_DUTY, 5'd0);
        do_access("pwm read period", 1'b1, 1'b0, LS_W, IO_BASE, 32'd0, 5'd14);
        check_value("pwm period readback", PWM_PERIOD, wb_seen.data);
        check_value("pwm period rd", 14, wb_seen.rd);
        do_access("pwm read duty", 1'b1, 1'b0, LS_W, IO_BASE | 32'h4, 32'd0, 5'd15);
        check_value("pwm duty readback", PWM_DUTY, wb_seen.data);
        repeat (2) @(posedge clk_i);
        for (int i = 0; i < PWM_PERIOD; i++) begin
            @(posedge clk_i);
            #3;
            high0 += int'(pwm0_o);
            high1 += int'(pwm1_o);
        end
        check_value("pwm0 high cycles", PWM_DUTY, high0);
        check_value("pwm1 high cycles", 0, high1);   // Channel 1 never set up
        report_test("pwm io", errs);
    endtask

    task automatic slow_memory_stall();
        int          errs;
        logic [31:0] addr;
        logic [31:0] expected;
        errs = errors;
        for (int i = 0; i < 3; i++) begin
            addr     = 32'h0000_1388 + 32'h1000 * i;   // Same index, new tag each time
            expected = load_expect(LS_W, addr);
            do_access("slow LW", 1'b1, 1'b0, LS_W, addr, 32'd0, 5'(16 + i));
            checks++;
            assert (stall_cycles > 0) else begin
                errors++;
                $display("Slow stall test: the load at %h hit, no miss was seen", addr);
            end
            check_value("slow writes during stall", 0, early_writes);
            check_value("slow reg_write", 1, wb_seen.reg_write);
            check_value("slow rd", 16 + i, wb_seen.rd);
            check_value("slow data", expected, wb_seen.data);
            @(posedge clk_i);
            #3;
            check_value("slow single write", 0, wb_o.reg_write);
        end
        report_test("slow stall", errs);
    endtask

    // Main memory model
    initial begin
        mem_avail_i = 1'b0;
        mem_ready_i = 1'b0;
        mem_rline_i = '0;
        rd_count    = 0;
        wr_count    = 0;
        for (int w = 0; w < MEM_WORDS; w++) begin
            mem_words[w] = fill_word(12'(w));
        end
        forever begin
            @(negedge clk_i);
            if (mem_o.req === 1'b1 && mem_avail_i) begin
                xfer = mem_o;
                @(posedge clk_i);                  // Accepted on this edge
                #2;
                mem_avail_i = 1'b0;
                if (xfer.we) begin
                    for (int k = 0; k < 4; k++) begin
                        mem_words[{xfer.addr[13:4], 2'(k)}] = xfer.line[32*k +: 32];
                    end
                    wr_count++;
                    last_wb_addr = xfer.addr;
                    last_wb_line = xfer.line;
                end else begin
                    rd_count++;
                    last_rd_addr = xfer.addr;
                end
                delay = 2 + int'($urandom % 7);    // 2 to 8 cycles
                repeat (delay - 1) @(posedge clk_i);
                #2;
                mem_ready_i = 1'b1;
                mem_rline_i = read_line(xfer.addr);
                @(posedge clk_i);
                #2;
                mem_ready_i = 1'b0;
            end else begin
                @(posedge clk_i);
                #2;
                mem_avail_i = ($urandom % 4) != 0;  // Busy about a quarter of the time
            end
        end
    end

    initial begin
        logic [31:0] word;
        void'($urandom(32'h94d1));
        checks      = 0;
        errors      = 0;
        rst_i       = 1'b0;
        req_i       = '0;
        reg_write_i = 1'b0;
        rd_i        = 5'd0;
        for (int w = 0; w < MEM_WORDS; w++) begin
            word = fill_word(12'(w));
            for (int b = 0; b < 4; b++) begin
                shadow[4*w + b] = word[8*b +: 8];
            end
        end
        repeat (10) @(posedge clk_i);
        #2;
        rst_i = 1'b1;

        reset_state();
        miss_refill();
        subword_access();
        dirty_eviction();
        pwm_channel();
        slow_memory_stall();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
mem_pkg.sv
dcache.sv
pwm_io.sv
mem_stage_ctrl.sv
mem_stage_top.sv
tb_mem_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_stage -f all.f -o tb_mem_stage > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/tb_mem_stage > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$SIM_LOG"
    echo "Simulation exited with an error, see $SIM_LOG"
    exit 1
fi

cat "$SIM_LOG"

if grep -q "Testbench failed" "$SIM_LOG"; then
    echo "FAIL"
    exit 1
fi

echo "PASS"
exit 0
